//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module cpuCoreTb -o cpuSim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed"
   exit $status
fi

./obj_dir/cpuSim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed"
   exit $status
fi
exit 0

//--- src/aluUnit.sv
module aluUnit (
   input  cpuPkg::aluFunc_t Func,
   input  cpuPkg::word_t    A,
   input  cpuPkg::word_t    B,
   input  logic             CarryIn,
   output cpuPkg::word_t    Result,
   output cpuPkg::flags_t   Flags
);

   logic [16:0] sum;
   logic        carry;
   logic        overflow;

   always_comb begin
      sum      = '0;
      carry    = 1'b0;
      overflow = 1'b0;
      Result   = '0;
      case (Func)
         cpuPkg::FnADD, cpuPkg::FnADC: begin
            sum      = {1'b0, A} + {1'b0, B} + {16'b0, (Func == cpuPkg::FnADC) & CarryIn};
            Result   = sum[15:0];
            carry    = sum[16];
            overflow = (A[15] == B[15]) && (Result[15] != A[15]);
         end
         cpuPkg::FnSUB: begin
            sum      = {1'b0, A} + {1'b0, ~B} + 17'd1;   // Carry out means no borrow
            Result   = sum[15:0];
            carry    = sum[16];
            overflow = (A[15] != B[15]) && (Result[15] != A[15]);
         end
         cpuPkg::FnAND: Result = A & B;
         cpuPkg::FnOR:  Result = A | B;
         cpuPkg::FnXOR: Result = A ^ B;
         cpuPkg::FnIMM: Result = B;
         cpuPkg::FnMEM: Result = A;
         default:       Result = '0;
      endcase
   end

   always_comb begin
      Flags               = '0;
      Flags[cpuPkg::flagZ] = (Result == '0);
      Flags[cpuPkg::flagN] = Result[15];
      Flags[cpuPkg::flagC] = carry;
      Flags[cpuPkg::flagV] = overflow;
   end

endmodule

//--- src/controlUnit.sv
module controlUnit (
   input  logic              Clock,
   input  logic              nReset,
   input  cpuPkg::opcode_t   Opcode,
   input  cpuPkg::flags_t    Flags,
   output cpuPkg::ctrlWord_t Ctrl,
   output cpuPkg::busCtrl_t  BusCtrl,
   output logic              CFlag
);

   typedef enum logic {fetch, execute} majorState_t;
   typedef enum logic [1:0] {fet1, fet2, fet3, fet4} fetchState_t;
   typedef enum logic [2:0] {exe1, exe2, exe3, exe4, exe5} exeState_t;

   majorState_t    state;
   fetchState_t    fetchSub;
   exeState_t      exeSub;
   exeState_t      lastExe;
   cpuPkg::flags_t statusReg;
   logic           statusWe;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= Flags;                  // Same edge as the result write
      end
   end

   assign CFlag = statusReg[cpuPkg::flagC];

   // Number of execute cycles per opcode
   always_comb begin
      case (Opcode)
         cpuPkg::JMP:              lastExe = exe2;
         cpuPkg::LDW, cpuPkg::STW: lastExe = exe5;
         default:                  lastExe = exe1;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state    <= fetch;
         fetchSub <= fet1;
         exeSub   <= exe1;
      end else if (state == fetch) begin
         case (fetchSub)
            fet1: fetchSub <= fet2;
            fet2: fetchSub <= fet3;
            fet3: fetchSub <= fet4;
            default: begin
               state    <= execute;
               fetchSub <= fet1;
               exeSub   <= exe1;
            end
         endcase
      end else if (exeSub == lastExe) begin
         state <= fetch;                       // Next instruction
      end else begin
         case (exeSub)
            exe1:    exeSub <= exe2;
            exe2:    exeSub <= exe3;
            exe3:    exeSub <= exe4;
            default: exeSub <= exe5;
         endcase
      end
   end

   always_comb begin
      Ctrl.AluOp   = cpuPkg::FnNOP;
      Ctrl.Op2Sel  = cpuPkg::Op2Rd2;
      Ctrl.ImmSel  = cpuPkg::ImmShort;
      Ctrl.Rs1Sel  = cpuPkg::Rs1Ra;
      Ctrl.WdSel   = cpuPkg::WdAlu;
      Ctrl.PcSel   = cpuPkg::Pc1;
      Ctrl.RegWe   = 1'b0;
      Ctrl.PcWe    = 1'b0;
      Ctrl.IrWe    = 1'b0;
      Ctrl.LrWe    = 1'b0;
      Ctrl.AluWe   = 1'b0;
      Ctrl.AddrOut = 1'b0;
      Ctrl.DataOut = 1'b0;
      BusCtrl      = '{Ale: 1'b0, nMe: 1'b1, nOe: 1'b1, nWe: 1'b1, Enb: 1'b0};
      statusWe     = 1'b0;
      if (state == fetch) begin
         case (fetchSub)
            fet1: begin
               BusCtrl.Ale  = nReset;           // PC as address, bus idle in reset
               Ctrl.AddrOut = nReset;
            end
            fet2: begin
               BusCtrl.nMe = 1'b0;
               BusCtrl.nOe = 1'b0;
            end
            fet3: begin
               BusCtrl.nMe = 1'b0;
               BusCtrl.nOe = 1'b0;
               BusCtrl.Enb = 1'b1;
            end
            default: Ctrl.IrWe = 1'b1;
         endcase
      end else begin
         case (exeSub)
            exe1: begin
               case (Opcode)
                  cpuPkg::ADD, cpuPkg::ADC, cpuPkg::SUB, cpuPkg::CMP,
                  cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR: begin
                     case (Opcode)
                        cpuPkg::ADD: Ctrl.AluOp = cpuPkg::FnADD;
                        cpuPkg::ADC: Ctrl.AluOp = cpuPkg::FnADC;
                        cpuPkg::AND: Ctrl.AluOp = cpuPkg::FnAND;
                        cpuPkg::OR:  Ctrl.AluOp = cpuPkg::FnOR;
                        cpuPkg::XOR: Ctrl.AluOp = cpuPkg::FnXOR;
                        default:     Ctrl.AluOp = cpuPkg::FnSUB;
                     endcase
                     Ctrl.RegWe = (Opcode != cpuPkg::CMP);   // Flags only for CMP
                     Ctrl.PcWe  = 1'b1;
                     statusWe   = 1'b1;
                  end
                  cpuPkg::ADDI, cpuPkg::SUBI: begin
                     Ctrl.AluOp  = (Opcode == cpuPkg::ADDI) ? cpuPkg::FnADD : cpuPkg::FnSUB;
                     Ctrl.Op2Sel = cpuPkg::Op2Imm;
                     Ctrl.RegWe  = 1'b1;
                     Ctrl.PcWe   = 1'b1;
                     statusWe    = 1'b1;
                  end
                  cpuPkg::LUI, cpuPkg::LLI: begin
                     Ctrl.AluOp  = cpuPkg::FnIMM;
                     Ctrl.Op2Sel = cpuPkg::Op2Imm;
                     Ctrl.ImmSel = cpuPkg::ImmLong;
                     Ctrl.RegWe  = 1'b1;
                     Ctrl.PcWe   = 1'b1;
                  end
                  cpuPkg::LDW, cpuPkg::STW, cpuPkg::JMP: begin
                     Ctrl.AluOp  = cpuPkg::FnADD;   // Ra plus offset
                     Ctrl.Op2Sel = cpuPkg::Op2Imm;
                     Ctrl.AluWe  = 1'b1;
                  end
                  cpuPkg::RET: begin
                     Ctrl.PcSel = cpuPkg::PcLr;
                     Ctrl.PcWe  = 1'b1;
                  end
                  default: Ctrl.PcWe = 1'b1;        // Unknown opcode skipped
               endcase
            end
            exe2: begin
               if (Opcode == cpuPkg::JMP) begin
                  Ctrl.LrWe  = 1'b1;                // Link before the PC moves
                  Ctrl.PcSel = cpuPkg::PcAlu;
                  Ctrl.PcWe  = 1'b1;
               end else begin
                  BusCtrl.Ale  = 1'b1;
                  Ctrl.DataOut = 1'b1;              // Address from ALU register
               end
            end
            exe3: begin
               if (Opcode == cpuPkg::LDW) begin
                  BusCtrl.nMe = 1'b0;
                  BusCtrl.nOe = 1'b0;
               end else begin
                  Ctrl.Rs1Sel = cpuPkg::Rs1Rd;      // Store data into ALU register
                  Ctrl.AluOp  = cpuPkg::FnMEM;
                  Ctrl.AluWe  = 1'b1;
               end
            end
            exe4: begin
               BusCtrl.nMe = 1'b0;
               if (Opcode == cpuPkg::LDW) begin
                  BusCtrl.nOe = 1'b0;
                  BusCtrl.Enb = 1'b1;
               end else begin
                  BusCtrl.nWe  = 1'b0;
                  Ctrl.DataOut = 1'b1;
               end
            end
            default: begin
               Ctrl.PcWe  = 1'b1;
               Ctrl.WdSel = cpuPkg::WdSys;
               Ctrl.RegWe = (Opcode == cpuPkg::LDW);
            end
         endcase
      end
   end

endmodule

//--- src/cpuCore.sv
module cpuCore (
   input  logic             Clock,
   input  logic             nReset,
   input  cpuPkg::word_t    BusIn,
   output cpuPkg::word_t    BusOut,
   output logic             BusDrive,
   output cpuPkg::busCtrl_t BusCtrl
);

   cpuPkg::ctrlWord_t ctrl;
   cpuPkg::opcode_t   opcode;
   cpuPkg::flags_t    flags;
   logic              cFlag;

   controlUnit control (
      .Clock   (Clock),
      .nReset  (nReset),
      .Opcode  (opcode),
      .Flags   (flags),
      .Ctrl    (ctrl),
      .BusCtrl (BusCtrl),
      .CFlag   (cFlag)
   );

   dataPath path (
      .Clock    (Clock),
      .nReset   (nReset),
      .Ctrl     (ctrl),
      .CFlag    (cFlag),
      .BusIn    (BusIn),
      .BusOut   (BusOut),
      .BusDrive (BusDrive),
      .Opcode   (opcode),
      .Flags    (flags)
   );

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

   typedef logic [15:0] word_t;       // Data and address word
   typedef logic [2:0]  regAddr_t;    // Register index
   typedef logic [3:0]  flags_t;      // Status bits

   localparam int numRegs = 8;

   // Bit positions inside flags_t
   localparam int flagC = 0;
   localparam int flagZ = 1;
   localparam int flagN = 2;
   localparam int flagV = 3;

   // Instruction bits 15 to 11
   typedef enum logic [4:0] {
      ADD  = 5'b00000,
      ADDI = 5'b00001,
      ADC  = 5'b00010,
      SUB  = 5'b00100,
      SUBI = 5'b00101,
      CMP  = 5'b00110,
      AND  = 5'b01000,
      OR   = 5'b01001,
      XOR  = 5'b01010,
      LUI  = 5'b01100,
      LLI  = 5'b01101,
      LDW  = 5'b10000,
      STW  = 5'b10001,
      JMP  = 5'b11000,
      RET  = 5'b11001
   } opcode_t;

   typedef enum logic [3:0] {
      FnNOP = 4'd0,
      FnADD = 4'd1,
      FnADC = 4'd2,
      FnSUB = 4'd3,
      FnAND = 4'd4,
      FnOR  = 4'd5,
      FnXOR = 4'd6,
      FnIMM = 4'd7,                   // Pass operand 2
      FnMEM = 4'd8                    // Pass operand 1
   } aluFunc_t;

   typedef enum logic {Op2Rd2, Op2Imm} op2Sel_t;
   typedef enum logic {ImmShort, ImmLong} immSel_t;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1Sel_t;
   typedef enum logic {WdAlu, WdSys} wdSel_t;
   typedef enum logic [1:0] {Pc1, PcAlu, PcLr} pcSel_t;

   // Memory strobes, all levels
   typedef struct packed {
      logic Ale;
      logic nMe;
      logic nOe;
      logic nWe;
      logic Enb;
   } busCtrl_t;

   typedef struct packed {
      aluFunc_t AluOp;
      op2Sel_t  Op2Sel;
      immSel_t  ImmSel;
      rs1Sel_t  Rs1Sel;
      wdSel_t   WdSel;
      pcSel_t   PcSel;
      logic     RegWe;
      logic     PcWe;
      logic     IrWe;
      logic     LrWe;
      logic     AluWe;
      logic     AddrOut;              // PC onto the bus
      logic     DataOut;              // ALU register onto the bus
   } ctrlWord_t;

endpackage

//--- src/dataPath.sv
module dataPath (
   input  logic              Clock,
   input  logic              nReset,
   input  cpuPkg::ctrlWord_t Ctrl,
   input  logic              CFlag,
   input  cpuPkg::word_t     BusIn,
   output cpuPkg::word_t     BusOut,
   output logic              BusDrive,
   output cpuPkg::opcode_t   Opcode,
   output cpuPkg::flags_t    Flags
);

   cpuPkg::word_t    pc;
   cpuPkg::word_t    ir;
   cpuPkg::word_t    lr;
   cpuPkg::word_t    aluReg;
   cpuPkg::word_t    busReg;
   cpuPkg::word_t    pcPlus1;
   cpuPkg::word_t    pcNext;
   cpuPkg::word_t    imm;
   cpuPkg::word_t    op2;
   cpuPkg::word_t    aluResult;
   cpuPkg::word_t    rdData1;
   cpuPkg::word_t    rdData2;
   cpuPkg::word_t    wrData;
   cpuPkg::regAddr_t rdAddr1;

   assign Opcode = cpuPkg::opcode_t'(ir[15:11]);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= '0;
         ir <= '0;
      end else begin
         if (Ctrl.PcWe)
            pc <= pcNext;
         if (Ctrl.IrWe)
            ir <= busReg;                       // Word sampled in the Enb cycle
      end
   end

   always_ff @(posedge Clock) begin
      busReg <= BusIn;
      if (Ctrl.LrWe)
         lr <= pcPlus1;                         // Return address
      if (Ctrl.AluWe)
         aluReg <= aluResult;
   end

   assign pcPlus1 = pc + 16'd1;

   always_comb begin
      case (Ctrl.PcSel)
         cpuPkg::PcAlu: pcNext = aluReg;
         cpuPkg::PcLr:  pcNext = lr;
         default:       pcNext = pcPlus1;
      endcase
   end

   // LUI fills the upper byte, LLI the lower
   always_comb begin
      if (Ctrl.ImmSel == cpuPkg::ImmShort)
         imm = {{11{ir[4]}}, ir[4:0]};
      else if (Opcode == cpuPkg::LUI)
         imm = {ir[7:0], 8'h00};
      else
         imm = {8'h00, ir[7:0]};
   end

   assign rdAddr1 = (Ctrl.Rs1Sel == cpuPkg::Rs1Rd) ? ir[10:8] : ir[7:5];
   assign op2     = (Ctrl.Op2Sel == cpuPkg::Op2Imm) ? imm : rdData2;
   assign wrData  = (Ctrl.WdSel == cpuPkg::WdSys) ? busReg : aluResult;

   registerFile regFile (
      .Clock   (Clock),
      .nReset  (nReset),
      .RdAddr1 (rdAddr1),
      .RdAddr2 (ir[4:2]),
      .WrAddr  (ir[10:8]),
      .We      (Ctrl.RegWe),
      .WrData  (wrData),
      .RdData1 (rdData1),
      .RdData2 (rdData2)
   );

   aluUnit alu (
      .Func    (Ctrl.AluOp),
      .A       (rdData1),
      .B       (op2),
      .CarryIn (CFlag),
      .Result  (aluResult),
      .Flags   (Flags)
   );

   // ALU register carries a load/store address or the store data
   assign BusOut   = Ctrl.DataOut ? aluReg : pc;
   assign BusDrive = Ctrl.AddrOut | Ctrl.DataOut;

endmodule

//--- src/registerFile.sv
module registerFile (
   input  logic             Clock,
   input  logic             nReset,
   input  cpuPkg::regAddr_t RdAddr1,
   input  cpuPkg::regAddr_t RdAddr2,
   input  cpuPkg::regAddr_t WrAddr,
   input  logic             We,
   input  cpuPkg::word_t    WrData,
   output cpuPkg::word_t    RdData1,
   output cpuPkg::word_t    RdData2
);

   cpuPkg::word_t regs [cpuPkg::numRegs];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < cpuPkg::numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (We) begin
         regs[WrAddr] <= WrData;
      end
   end

   // Asynchronous read ports
   assign RdData1 = regs[RdAddr1];
   assign RdData2 = regs[RdAddr2];

endmodule

//--- tb/cpuCoreTb.sv
module cpuCoreTb;

   localparam int resetCycles = 10;
   // Four resets plus the cycle counts of the four programs
   localparam int timeoutCycles = 2 * (4 * (resetCycles + 1) + 105 + 100 + 46 + 44);

   logic              Clock;
   logic              nReset;
   cpuPkg::word_t     BusIn;
   cpuPkg::word_t     BusOut;
   logic              BusDrive;
   cpuPkg::busCtrl_t  BusCtrl;
   int                cycles = 0;
   int                seed = 51;
   cpuPkg::word_t     progAddr;

   cpuCore DUT (
      .Clock    (Clock),
      .nReset   (nReset),
      .BusIn    (BusIn),
      .BusOut   (BusOut),
      .BusDrive (BusDrive),
      .BusCtrl  (BusCtrl)
   );

   memoryModel memory (
      .Clock    (Clock),
      .BusOut   (BusOut),
      .BusDrive (BusDrive),
      .BusCtrl  (BusCtrl),
      .BusIn    (BusIn)
   );

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;
   end

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "%s", msg);
   endtask

   always @(posedge Clock) begin
      cycles <= cycles + 1;
      if (cycles >= timeoutCycles)
         failRun("timeout: the expected memory write never arrived");
   end

   task automatic checkValue(input string name, input cpuPkg::word_t actual,
                             input cpuPkg::word_t expected);
      if (actual !== expected)
         failRun($sformatf("mismatch %s: got 0x%h expected 0x%h", name, actual, expected));
   endtask

   // Instruction encoders
   function automatic cpuPkg::word_t rType(input cpuPkg::opcode_t op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [2:0] rb);
      return {op, rd, ra, rb, 2'b00};
   endfunction

   function automatic cpuPkg::word_t iType(input cpuPkg::opcode_t op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [4:0] imm);
      return {op, rd, ra, imm};
   endfunction

   function automatic cpuPkg::word_t longImm(input cpuPkg::opcode_t op, input logic [2:0] rd,
                                             input logic [7:0] imm);
      return {op, rd, imm};
   endfunction

   function automatic int writeCountAt(input cpuPkg::word_t addr);
      int n;
      n = 0;
      for (int i = 0; i < memory.logCount; i++) begin
         if (memory.logAddr[i] == addr)
            n++;
      end
      return n;
   endfunction

   task automatic placeWord(input cpuPkg::word_t w);
      memory.loadWord(progAddr, w);
      progAddr = progAddr + 16'd1;
   endtask

   // Full 16-bit constant in rd, tmp is clobbered
   task automatic loadConstant(input logic [2:0] rd, input logic [2:0] tmp,
                               input cpuPkg::word_t value);
      placeWord(longImm(cpuPkg::LUI, rd, value[15:8]));
      placeWord(longImm(cpuPkg::LLI, tmp, value[7:0]));
      placeWord(rType(cpuPkg::OR, rd, rd, tmp));
   endtask

   task automatic startReset();
      @(posedge Clock);
      nReset <= 1'b0;
      @(posedge Clock);                        // Core idle from here on
      memory.fillMemory();
      memory.clearLog();
      progAddr = '0;
   endtask

   // First reset cycle already spent in startReset
   task automatic releaseReset();
      repeat (resetCycles - 1) @(posedge Clock);
      nReset <= 1'b1;
   endtask

   task automatic waitWrite(input cpuPkg::word_t addr);
      do begin
         @(negedge Clock);
      end while (writeCountAt(addr) == 0);
   endtask

   // The single logged write at addr
   task automatic storedWord(input cpuPkg::word_t addr, output cpuPkg::word_t data);
      data = '0;
      if (writeCountAt(addr) != 1)
         failRun($sformatf("expected exactly one write to address 0x%h", addr));
      for (int i = 0; i < memory.logCount; i++) begin
         if (memory.logAddr[i] == addr)
            data = memory.logData[i];
      end
   endtask

   task automatic aluOperations();
      cpuPkg::word_t a;
      cpuPkg::word_t b;
      cpuPkg::word_t got;
      a = cpuPkg::word_t'($random(seed));
      b = cpuPkg::word_t'($random(seed));
      startReset();
      loadConstant(3'd1, 3'd2, a);
      loadConstant(3'd3, 3'd4, b);
      placeWord(longImm(cpuPkg::LLI, 3'd7, 8'h80));   // Result base
      placeWord(rType(cpuPkg::ADD, 3'd5, 3'd1, 3'd3));
      placeWord(iType(cpuPkg::STW, 3'd5, 3'd7, 5'd0));
      placeWord(rType(cpuPkg::SUB, 3'd5, 3'd1, 3'd3));
      placeWord(iType(cpuPkg::STW, 3'd5, 3'd7, 5'd1));
      placeWord(rType(cpuPkg::AND, 3'd5, 3'd1, 3'd3));
      placeWord(iType(cpuPkg::STW, 3'd5, 3'd7, 5'd2));
      placeWord(rType(cpuPkg::OR, 3'd5, 3'd1, 3'd3));
      placeWord(iType(cpuPkg::STW, 3'd5, 3'd7, 5'd3));
      placeWord(rType(cpuPkg::XOR, 3'd5, 3'd1, 3'd3));
      placeWord(iType(cpuPkg::STW, 3'd5, 3'd7, 5'd4));
      releaseReset();
      waitWrite(16'h0084);
      storedWord(16'h0080, got);
      checkValue("add", got, a + b);
      storedWord(16'h0081, got);
      checkValue("sub", got, a - b);
      storedWord(16'h0082, got);
      checkValue("and", got, a & b);
      storedWord(16'h0083, got);
      checkValue("or", got, a | b);
      storedWord(16'h0084, got);
      checkValue("xor", got, a ^ b);
   endtask

   task automatic immediatesAndCarry();
      cpuPkg::word_t a;
      cpuPkg::word_t got;
      // Top bit set, so the first ADC carries out as well
      a = cpuPkg::word_t'($random(seed)) | 16'h8000;
      startReset();
      loadConstant(3'd1, 3'd2, a);
      placeWord(longImm(cpuPkg::LLI, 3'd7, 8'h80));
      placeWord(iType(cpuPkg::ADDI, 3'd2, 3'd1, 5'b11101));   // Minus 3
      placeWord(iType(cpuPkg::SUBI, 3'd3, 3'd1, 5'b11011));   // Minus 5
      placeWord(longImm(cpuPkg::LUI, 3'd4, 8'h80));
      placeWord(rType(cpuPkg::ADD, 3'd5, 3'd4, 3'd4));        // Carry out set
      placeWord(rType(cpuPkg::ADC, 3'd5, 3'd1, 3'd1));
      placeWord(rType(cpuPkg::CMP, 3'd1, 3'd0, 3'd4));        // Borrow clears C
      placeWord(rType(cpuPkg::ADC, 3'd6, 3'd1, 3'd1));
      placeWord(iType(cpuPkg::STW, 3'd2, 3'd7, 5'd0));
      placeWord(iType(cpuPkg::STW, 3'd3, 3'd7, 5'd1));
      placeWord(iType(cpuPkg::STW, 3'd5, 3'd7, 5'd2));
      placeWord(iType(cpuPkg::STW, 3'd6, 3'd7, 5'd3));
      placeWord(iType(cpuPkg::STW, 3'd1, 3'd7, 5'd4));
      releaseReset();
      waitWrite(16'h0084);
      storedWord(16'h0080, got);
      checkValue("addi", got, a - 16'd3);
      storedWord(16'h0081, got);
      checkValue("subi", got, a + 16'd5);
      storedWord(16'h0082, got);
      checkValue("adc carry", got, a + a + 16'd1);
      storedWord(16'h0083, got);
      checkValue("adc after cmp", got, a + a);
      storedWord(16'h0084, got);
      checkValue("cmp dest", got, a);
   endtask

   task automatic loadThenStore();
      cpuPkg::word_t d1;
      cpuPkg::word_t d2;
      cpuPkg::word_t got;
      d1 = cpuPkg::word_t'($random(seed));
      d2 = cpuPkg::word_t'($random(seed));
      startReset();
      memory.loadWord(16'h0093, d1);
      memory.loadWord(16'h009E, d2);
      placeWord(longImm(cpuPkg::LLI, 3'd7, 8'h90));
      placeWord(longImm(cpuPkg::LLI, 3'd6, 8'hA0));
      placeWord(iType(cpuPkg::LDW, 3'd1, 3'd7, 5'd3));
      placeWord(iType(cpuPkg::STW, 3'd1, 3'd6, 5'd5));
      placeWord(iType(cpuPkg::LDW, 3'd2, 3'd6, 5'b11110));    // Minus 2
      placeWord(iType(cpuPkg::STW, 3'd2, 3'd7, 5'b11111));    // Minus 1
      releaseReset();
      waitWrite(16'h008F);
      storedWord(16'h00A5, got);
      checkValue("ldw positive offset", got, d1);
      storedWord(16'h008F, got);
      checkValue("ldw negative offset", got, d2);
      if (memory.logCount != 2)
         failRun("load/store program wrote more than two words");
   endtask

   task automatic jumpAndReturn();
      cpuPkg::word_t v;
      cpuPkg::word_t got;
      v = {8'h00, 8'($random(seed))};
      startReset();
      placeWord(longImm(cpuPkg::LLI, 3'd7, 8'h80));
      placeWord(longImm(cpuPkg::LLI, 3'd1, v[7:0]));
      placeWord(longImm(cpuPkg::LLI, 3'd2, 8'h07));            // Jump target
      placeWord(iType(cpuPkg::JMP, 3'd0, 3'd2, 5'd0));
      placeWord(iType(cpuPkg::STW, 3'd1, 3'd7, 5'd1));         // After return
      placeWord(iType(cpuPkg::JMP, 3'd0, 3'd2, 5'b11110));     // Park at 5
      placeWord(iType(cpuPkg::STW, 3'd1, 3'd7, 5'd2));         // Jumped over
      placeWord(iType(cpuPkg::STW, 3'd1, 3'd7, 5'd0));
      placeWord(longImm(cpuPkg::RET, 3'd0, 8'h00));
      releaseReset();
      waitWrite(16'h0081);
      storedWord(16'h0080, got);
      checkValue("jump target store", got, v);
      storedWord(16'h0081, got);
      checkValue("return store", got, v);
      if (writeCountAt(16'h0082) != 0)
         failRun("the instruction skipped by the jump stored a word");
   endtask

   initial begin
      nReset = 1'b0;
      aluOperations();
      immediatesAndCarry();
      loadThenStore();
      jumpAndReturn();
      $display("** PASS **");
      $finish;
   end

endmodule

//--- tb/cpuCore_props.sv
module cpuCore_props (
   input logic             Clock,
   input logic             nReset,
   input cpuPkg::busCtrl_t BusCtrl,
   input logic             BusDrive
);

   logic aleSeen;
   logic busQuiet;

   assign busQuiet = BusCtrl.nMe && BusCtrl.nOe && BusCtrl.nWe && !BusCtrl.Enb && !BusDrive;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         aleSeen <= 1'b0;
      else if (BusCtrl.Ale)
         aleSeen <= 1'b1;                       // First address phase done
   end

   quietInReset: assert property (@(posedge Clock) !nReset |-> (busQuiet && !BusCtrl.Ale))
      else $error("bus strobes active during reset");

   quietBeforeAle: assert property (@(posedge Clock) disable iff (!nReset)
      (!aleSeen && !BusCtrl.Ale) |-> busQuiet)
      else $error("bus strobes active before the first address latch");

   writeDriven: assert property (@(posedge Clock) disable iff (!nReset)
      !BusCtrl.nWe |-> BusDrive)
      else $error("write strobe low while the core does not drive the bus");

   noSampleWhileDriving: assert property (@(posedge Clock) disable iff (!nReset)
      !(BusCtrl.Enb && BusDrive))
      else $error("bus sampled while the core drives it");

endmodule

bind cpuCore cpuCore_props props (
   .Clock    (Clock),
   .nReset   (nReset),
   .BusCtrl  (BusCtrl),
   .BusDrive (BusDrive)
);

//--- tb/memoryModel.sv
module memoryModel (
   input  logic             Clock,
   input  cpuPkg::word_t    BusOut,
   input  logic             BusDrive,
   input  cpuPkg::busCtrl_t BusCtrl,
   output cpuPkg::word_t    BusIn
);

   localparam int logDepth = 64;

   cpuPkg::word_t mem [65536];
   cpuPkg::word_t addrLatch = '0;
   cpuPkg::word_t logAddr [logDepth];
   cpuPkg::word_t logData [logDepth];
   int            logCount = 0;

   // Read data only while the read strobes are low
   assign BusIn = (!BusCtrl.nMe && !BusCtrl.nOe) ? mem[addrLatch] : '0;

   always @(posedge Clock) begin
      if (BusCtrl.Ale)
         addrLatch <= BusOut;                   // Address phase
      if (!BusCtrl.nMe && !BusCtrl.nWe && BusDrive) begin
         mem[addrLatch] <= BusOut;
         if (logCount < logDepth) begin
            logAddr[logCount] <= addrLatch;
            logData[logCount] <= BusOut;
            logCount          <= logCount + 1;
         end
      end
   end

   // Unused opcode 11110 in the top bits, so stray fetches are skipped
   task automatic fillMemory();
      for (int a = 0; a < 65536; a++) begin
         mem[a] <= {5'b11110, a[15:5] ^ a[10:0]};
      end
   endtask

   task automatic loadWord(input cpuPkg::word_t addr, input cpuPkg::word_t data);
      mem[addr] <= data;
   endtask

   task automatic clearLog();
      logCount <= 0;
   endtask

endmodule

//--- verilog.f
src/cpuPkg.sv
src/aluUnit.sv
src/registerFile.sv
src/controlUnit.sv
src/dataPath.sv
src/cpuCore.sv
tb/memoryModel.sv
tb/cpuCore_props.sv
tb/cpuCoreTb.sv
